// ==== card_sequencer.sv ====
/*
 * card start-up, command/response, sector read and sector write FSM
 * with the host start/done/ack handshake
 */
`default_nettype none

module card_sequencer import sd_proto_pkg::*, sdspi_buf_pkg::*; (
   input  logic                     controller_clk,
   input  logic                     reset,
   // host handshake
   input  logic [sector_addr_w-1:0] sdcard_addr,
   input  logic                     read_start,
   input  logic                     read_ack,
   input  logic                     write_start,
   input  logic                     write_ack,
   output logic                     idle,
   output logic                     read_done,
   output logic                     write_done,
   output logic                     error,
   // card select
   output logic                     sdcard_cs,
   // byte engine
   output logic                     fast,
   output logic                     byte_req,
   output logic [7:0]               tx_byte,
   input  logic                     byte_ack,
   input  logic [7:0]               rx_byte,
   // buffers
   output logic [buf_addr_w-1:0]    wbuf_index,
   output logic [buf_addr_w-1:0]    rbuf_index,
   input  buf_word_u                wbuf_word,
   output buf_word_u                rbuf_word,
   output logic                     rbuf_we
);

   seq_state_t  state;
   seq_state_t  ret_st;      // check state after R1
   logic [47:0] cmd_frame;   // shifted out a byte at a time
   logic [7:0]  r1;
   logic [9:0]  byte_cnt;
   logic        op_write;    // current operation is a write
   logic        eng_free;
   logic        got_byte;
   logic        sends_byte;
   logic [7:0]  tx_next;

   assign eng_free = !byte_req && !byte_ack;  // previous byte fully closed
   assign got_byte = byte_req && byte_ack;    // one cycle per byte

   assign sends_byte = state inside {st_init_clk, st_cmd, st_r1_poll, st_r7_skip,
                                     st_rd_token, st_rd_data, st_rd_crc,
                                     st_wr_gap, st_wr_token, st_wr_data, st_wr_crc,
                                     st_wr_resp, st_wr_busy};

   // byte to put on MOSI in the current state
   always_comb begin
      case (state)
         st_cmd:      tx_next = cmd_frame[47:40];
         st_wr_token: tx_next = token_start_block;
         st_wr_data:  tx_next = byte_cnt[0] ? wbuf_word.bytes.hi : wbuf_word.bytes.lo;
         default:     tx_next = 8'hFF;  // idle clocks and polling
      endcase
   end

   // **************************************************
   // main FSM
   // **************************************************
   always_ff @(posedge controller_clk) begin
      if (reset) begin
         state      <= st_reset;
         idle       <= 1'b0;
         read_done  <= 1'b0;
         write_done <= 1'b0;
         error      <= 1'b0;
         sdcard_cs  <= 1'b1;
         fast       <= 1'b0;
         byte_req   <= 1'b0;
         rbuf_we    <= 1'b0;
      end else begin
         rbuf_we <= 1'b0;

         // byte handshake with the engine
         if (eng_free && sends_byte) begin
            tx_byte  <= tx_next;
            byte_req <= 1'b1;
         end
         if (got_byte) begin
            byte_req <= 1'b0;
            byte_cnt <= byte_cnt + 1'b1;
         end

         case (state)
            st_reset: begin
               sdcard_cs <= 1'b1;
               byte_cnt  <= '0;
               state     <= st_init_clk;
            end
            st_init_clk:
               if (got_byte && byte_cnt == 10'(init_idle_bytes - 1)) begin
                  sdcard_cs <= 1'b0;  // select card for CMD0
                  cmd_frame <= cmd0_frame;
                  ret_st    <= st_chk_cmd0;
                  byte_cnt  <= '0;
                  state     <= st_cmd;
               end

            // six command bytes, then R1 polling
            st_cmd:
               if (got_byte) begin
                  cmd_frame <= {cmd_frame[39:0], 8'hFF};
                  if (byte_cnt == 10'd5) begin
                     byte_cnt <= '0;
                     state    <= st_r1_poll;
                  end
               end
            st_r1_poll:
               if (got_byte) begin
                  if (!rx_byte[7]) begin  // R1 has MSB clear
                     r1       <= rx_byte;
                     byte_cnt <= '0;
                     state    <= (ret_st == st_chk_cmd8) ? st_r7_skip : ret_st;
                  end else if (byte_cnt == 10'(r1_wait_limit - 1)) begin
                     state <= fast ? st_fail : st_reset;  // start-up retries
                  end
               end
            st_r7_skip:  // R7 payload, not kept
               if (got_byte && byte_cnt == 10'd3) begin
                  byte_cnt <= '0;
                  state    <= st_chk_cmd8;
               end

            // start-up response checks
            st_chk_cmd0:
               if (r1 == r1_idle) begin
                  cmd_frame <= cmd8_frame;
                  ret_st    <= st_chk_cmd8;
                  state     <= st_cmd;
               end else begin
                  state <= st_reset;
               end
            st_chk_cmd8:
               if (r1 == r1_idle) begin
                  cmd_frame <= cmd55_frame;
                  ret_st    <= st_chk_cmd55;
                  state     <= st_cmd;
               end else begin
                  state <= st_reset;
               end
            st_chk_cmd55:
               if (r1 == r1_idle) begin
                  cmd_frame <= acmd41_frame;
                  ret_st    <= st_chk_acmd41;
                  state     <= st_cmd;
               end else begin
                  state <= st_reset;
               end
            st_chk_acmd41:
               if (r1 == r1_ready) begin
                  fast  <= 1'b1;  // card ready, full speed from now on
                  state <= st_wait;
               end else begin
                  cmd_frame <= cmd55_frame;  // card still busy, ask again
                  ret_st    <= st_chk_cmd55;
                  state     <= st_cmd;
               end

            // **************************************************
            // host handshake
            // **************************************************
            st_wait: begin
               idle <= 1'b1;
               if (read_ack)
                  read_done <= 1'b0;
               if (write_ack)
                  write_done <= 1'b0;
               if (idle && !read_done && !write_done && !read_ack && !write_ack &&
                   (read_start || write_start)) begin
                  op_write   <= !read_start;  // read wins
                  cmd_frame  <= {read_start ? cmd_read_single : cmd_write_single,
                                 {(32 - sector_addr_w){1'b0}}, sdcard_addr, 8'h01};
                  ret_st     <= st_op_check;
                  wbuf_index <= '0;
                  error      <= 1'b0;
                  idle       <= 1'b0;
                  byte_cnt   <= '0;
                  state      <= st_cmd;
               end
            end
            st_op_check:
               if (r1 != r1_ready)
                  state <= st_fail;
               else
                  state <= op_write ? st_wr_gap : st_rd_token;

            // sector read
            st_rd_token:
               if (got_byte) begin
                  if (rx_byte == token_start_block) begin
                     byte_cnt <= '0;
                     state    <= st_rd_data;
                  end else if (&byte_cnt) begin
                     state <= st_fail;
                  end
               end
            st_rd_data:
               if (got_byte) begin
                  if (byte_cnt[0]) begin  // second byte completes the word
                     rbuf_word.bytes.hi <= rx_byte;
                     rbuf_index         <= byte_cnt[buf_addr_w:1];
                     rbuf_we            <= 1'b1;
                  end else begin
                     rbuf_word.bytes.lo <= rx_byte;
                  end
                  if (byte_cnt == 10'(2 * buf_depth - 1)) begin
                     byte_cnt <= '0;
                     state    <= st_rd_crc;
                  end
               end
            st_rd_crc:  // CRC ignored
               if (got_byte && byte_cnt == 10'd1)
                  state <= st_finish;

            // sector write
            st_wr_gap:
               if (got_byte)
                  state <= st_wr_token;
            st_wr_token:
               if (got_byte) begin
                  byte_cnt <= '0;
                  state    <= st_wr_data;
               end
            st_wr_data:
               if (got_byte) begin
                  if (byte_cnt[0])
                     wbuf_index <= wbuf_index + 1'b1;  // next word prefetch
                  if (byte_cnt == 10'(2 * buf_depth - 1)) begin
                     byte_cnt <= '0;
                     state    <= st_wr_crc;
                  end
               end
            st_wr_crc:  // dummy CRC
               if (got_byte && byte_cnt == 10'd1) begin
                  byte_cnt <= '0;
                  state    <= st_wr_resp;
               end
            st_wr_resp:
               if (got_byte) begin
                  byte_cnt <= '0;
                  state    <= (rx_byte[3:0] == data_accepted) ? st_wr_busy : st_fail;
               end
            st_wr_busy:  // card holds MISO low while programming
               if (got_byte) begin
                  if (rx_byte != 8'h00)
                     state <= st_finish;
                  else if (&byte_cnt)
                     state <= st_fail;
               end

            st_finish, st_fail: begin
               read_done  <= !op_write;
               write_done <= op_write;
               error      <= (state == st_fail);
               state      <= st_wait;
            end
            default: state <= st_reset;
         endcase
      end
   end

endmodule

`default_nettype wire

// ==== sd_card_model.sv ====
/*
 * behavioral SPI-mode SD card, 64 sectors of 512 bytes
 */
`default_nettype none

module sd_card_model import sd_proto_pkg::*; (
   input  logic sdcard_cs,
   input  logic sdcard_sclk,
   input  logic sdcard_mosi,
   output logic sdcard_miso
);
   timeunit 1ns;
   timeprecision 100ps;

   localparam int num_sectors  = 64;
   localparam int sector_bytes = 512;

   logic [7:0] mem [num_sectors * sector_bytes];
   logic [7:0] out_q [$];          // bytes waiting for MISO
   logic [7:0] rx_sr;
   logic [7:0] tx_sr   = 8'hFF;
   logic [2:0] bit_cnt = '0;
   logic [7:0] cmd_buf [6];
   int         cmd_cnt    = 0;
   int         acmd41_cnt = 0;
   int         wr_cnt;
   int         wr_base;
   logic [1:0] mode = 2'd0;        // 0 command, 1 wait for token, 2 write data

   assign sdcard_miso = sdcard_cs ? 1'b1 : tx_sr[7];

   initial begin
      for (int i = 0; i < num_sectors * sector_bytes; i++)
         mem[i] = 8'((i / sector_bytes) * 3 + i % sector_bytes);
   end

   // **************************************************
   // command decode, response queued after one Ncr byte
   // **************************************************
   task automatic run_command();
      logic [31:0] arg;
      arg = {cmd_buf[1], cmd_buf[2], cmd_buf[3], cmd_buf[4]};
      out_q.push_back(8'hFF);
      if (cmd_buf[0] == cmd0_frame[47:40] || cmd_buf[0] == cmd55_frame[47:40]) begin
         out_q.push_back(r1_idle);
      end else if (cmd_buf[0] == cmd8_frame[47:40]) begin
         out_q.push_back(r1_idle);
         for (int i = 1; i <= 4; i++)
            out_q.push_back(cmd_buf[i]);  // R7 echoes the argument
      end else if (cmd_buf[0] == acmd41_frame[47:40]) begin
         out_q.push_back((acmd41_cnt < 2) ? r1_idle : r1_ready);
         acmd41_cnt++;
      end else if (cmd_buf[0] == cmd_read_single || cmd_buf[0] == cmd_write_single) begin
         if (arg >= num_sectors) begin
            out_q.push_back(8'h20);  // address error
         end else if (cmd_buf[0] == cmd_read_single) begin
            out_q.push_back(r1_ready);
            out_q.push_back(8'hFF);
            out_q.push_back(token_start_block);
            for (int i = 0; i < sector_bytes; i++)
               out_q.push_back(mem[arg * sector_bytes + i]);
            out_q.push_back(8'hFF);  // CRC
            out_q.push_back(8'hFF);
         end else begin
            out_q.push_back(r1_ready);
            wr_base = arg * sector_bytes;
            mode    = 2'd1;
         end
      end else begin
         out_q.push_back(8'h04);  // illegal command
      end
   endtask

   task automatic take_byte(input logic [7:0] b);
      case (mode)
         2'd0:
            if (cmd_cnt > 0 || b[7:6] == 2'b01) begin
               cmd_buf[cmd_cnt] = b;
               cmd_cnt++;
               if (cmd_cnt == 6) begin
                  cmd_cnt = 0;
                  run_command();
               end
            end
         2'd1:
            if (b == token_start_block) begin
               wr_cnt = 0;
               mode   = 2'd2;
            end
         default: begin
            if (wr_cnt < sector_bytes)
               mem[wr_base + wr_cnt] = b;
            wr_cnt++;
            if (wr_cnt == sector_bytes + 2) begin  // data and CRC in
               out_q.push_back({3'b111, 1'b0, data_accepted});
               repeat (3)
                  out_q.push_back(8'h00);  // busy while programming
               mode = 2'd0;
            end
         end
      endcase
   endtask

   always @(posedge sdcard_sclk) begin : sample_mosi
      if (sdcard_cs) begin
         bit_cnt = '0;
         tx_sr   = 8'hFF;
         cmd_cnt = 0;
         out_q.delete();
      end else begin
         rx_sr = {rx_sr[6:0], sdcard_mosi};
         if (bit_cnt == 3'd7)
            take_byte(rx_sr);
         bit_cnt = bit_cnt + 1'b1;
      end
   end

   // MISO changes on the falling edge, next byte after the 8th
   always @(negedge sdcard_sclk) begin : drive_miso
      if (!sdcard_cs) begin
         if (bit_cnt == 3'd0)
            tx_sr = (out_q.size() > 0) ? out_q.pop_front() : 8'hFF;
         else
            tx_sr = {tx_sr[6:0], 1'b1};
      end
   end

endmodule

`default_nettype wire

// ==== sd_proto_pkg.sv ====
/*
 * SD card SPI-mode protocol constants: command frames, response
 * and token values, sequencer state encoding
 */
`default_nettype none

package sd_proto_pkg;

   // **************************************************
   // fixed command frames, CRC included
   // **************************************************
   localparam logic [47:0] cmd0_frame   = 48'h40_0000_0000_95;  // GO_IDLE_STATE
   localparam logic [47:0] cmd8_frame   = 48'h48_0000_01AA_87;  // SEND_IF_COND, 3.3V
   localparam logic [47:0] cmd55_frame  = 48'h77_0000_0000_65;  // APP_CMD
   localparam logic [47:0] acmd41_frame = 48'h69_4000_0000_77;  // SD_SEND_OP_COND, HCS

   localparam logic [7:0] cmd_read_single  = 8'h51;  // CMD17
   localparam logic [7:0] cmd_write_single = 8'h58;  // CMD24

   // response and token values
   localparam logic [7:0] r1_idle           = 8'h01;
   localparam logic [7:0] r1_ready          = 8'h00;
   localparam logic [7:0] token_start_block = 8'hFE;
   localparam logic [3:0] data_accepted     = 4'h5;  // low nibble of data response

   localparam int r1_wait_limit   = 16;  // poll bytes before timeout
   localparam int init_idle_bytes = 10;  // 80 clocks with CS high

   // **************************************************
   // sequencer states
   // **************************************************
   typedef enum logic [4:0] {
      st_reset, st_init_clk,
      st_cmd, st_r1_poll, st_r7_skip,
      st_chk_cmd0, st_chk_cmd8, st_chk_cmd55, st_chk_acmd41,
      st_wait, st_op_check,
      st_rd_token, st_rd_data, st_rd_crc,
      st_wr_gap, st_wr_token, st_wr_data, st_wr_crc, st_wr_resp, st_wr_busy,
      st_finish, st_fail
   } seq_state_t;

endpackage

`default_nettype wire

// ==== sdspi_buf_pkg.sv ====
/*
 * sector buffer geometry, host word layout and card clock divider values
 */
`default_nettype none

package sdspi_buf_pkg;

   localparam int sector_addr_w = 27;
   localparam int buf_depth     = 256;                // words per sector
   localparam int buf_addr_w    = $clog2(buf_depth);
   localparam int word_w        = 16;

   // one host word, or the two bytes it occupies on the wire
   typedef union packed {
      logic [word_w-1:0] word;
      struct packed {
         logic [7:0] hi;
         logic [7:0] lo;  // sent first
      } bytes;
   } buf_word_u;

   // controller clocks per card clock
   localparam int slow_div = 64;  // start-up
   localparam int fast_div = 2;   // after ACMD41 ready

endpackage

`default_nettype wire

// ==== sdspi_chk.sv ====
/*
 * concurrent assertions on the host handshake, bound to sdspi_top
 */
`default_nettype none

module sdspi_chk (
   input logic controller_clk,
   input logic reset,
   input logic read_ack,
   input logic write_ack,
   input logic read_done,
   input logic write_done,
   input logic error
);
   timeunit 1ns;
   timeprecision 100ps;

   int fail_cnt = 0;  // read by the testbench at the end

   // done may only rise while the host holds ack low
   rd_done_after_ack: assert property (@(posedge controller_clk) disable iff (reset)
      $rose(read_done) |-> !$past(read_ack))
      else begin
         fail_cnt++;
         $error("read_done rose while read_ack was high");
      end

   wr_done_after_ack: assert property (@(posedge controller_clk) disable iff (reset)
      $rose(write_done) |-> !$past(write_ack))
      else begin
         fail_cnt++;
         $error("write_done rose while write_ack was high");
      end

   one_done: assert property (@(posedge controller_clk) disable iff (reset)
      !(read_done && write_done))
      else begin
         fail_cnt++;
         $error("read_done and write_done high together");
      end

   error_with_done: assert property (@(posedge controller_clk) disable iff (reset)
      $rose(error) |-> (read_done || write_done))
      else begin
         fail_cnt++;
         $error("error rose without a done");
      end

endmodule

bind sdspi_top sdspi_chk i_sdspi_chk (.*);

`default_nettype wire

// ==== sdspi_top.sv ====
/*
 * SD card SPI controller top: sector buffers, command sequencer, byte engine
 */
`default_nettype none

module sdspi_top import sdspi_buf_pkg::*; (
   input  logic                     controller_clk,
   input  logic                     reset,
   // host handshake
   input  logic [sector_addr_w-1:0] sdcard_addr,
   input  logic                     read_start,
   input  logic                     read_ack,
   input  logic                     write_start,
   input  logic                     write_ack,
   output logic                     idle,
   output logic                     read_done,
   output logic                     write_done,
   output logic                     error,
   // host buffer port
   input  logic [buf_addr_w-1:0]    xfer_addr,
   input  logic [word_w-1:0]        xfer_in,
   input  logic                     xfer_write,
   output logic [word_w-1:0]        xfer_out,
   // card pins
   output logic                     sdcard_cs,
   output logic                     sdcard_sclk,
   output logic                     sdcard_mosi,
   input  logic                     sdcard_miso
);

   // sequencer <-> engine
   logic       fast;
   logic       byte_req;
   logic       byte_ack;
   logic [7:0] tx_byte;
   logic [7:0] rx_byte;

   // sequencer <-> buffers
   logic [buf_addr_w-1:0] wbuf_index;
   logic [buf_addr_w-1:0] rbuf_index;
   buf_word_u             wbuf_word;
   buf_word_u             rbuf_word;
   logic                  rbuf_we;

   sector_buffers i_sector_buffers (
      .controller_clk (controller_clk),
      .xfer_addr      (xfer_addr),
      .xfer_in        (xfer_in),
      .xfer_write     (xfer_write),
      .xfer_out       (xfer_out),
      .wbuf_index     (wbuf_index),
      .wbuf_word      (wbuf_word),
      .rbuf_index     (rbuf_index),
      .rbuf_word      (rbuf_word),
      .rbuf_we        (rbuf_we)
   );

   card_sequencer i_card_sequencer (
      .controller_clk (controller_clk),
      .reset          (reset),
      .sdcard_addr    (sdcard_addr),
      .read_start     (read_start),
      .read_ack       (read_ack),
      .write_start    (write_start),
      .write_ack      (write_ack),
      .idle           (idle),
      .read_done      (read_done),
      .write_done     (write_done),
      .error          (error),
      .sdcard_cs      (sdcard_cs),
      .fast           (fast),
      .byte_req       (byte_req),
      .tx_byte        (tx_byte),
      .byte_ack       (byte_ack),
      .rx_byte        (rx_byte),
      .wbuf_index     (wbuf_index),
      .rbuf_index     (rbuf_index),
      .wbuf_word      (wbuf_word),
      .rbuf_word      (rbuf_word),
      .rbuf_we        (rbuf_we)
   );

   spi_byte_engine i_spi_byte_engine (
      .controller_clk (controller_clk),
      .reset          (reset),
      .fast           (fast),
      .byte_req       (byte_req),
      .tx_byte        (tx_byte),
      .byte_ack       (byte_ack),
      .rx_byte        (rx_byte),
      .sdcard_sclk    (sdcard_sclk),
      .sdcard_mosi    (sdcard_mosi),
      .sdcard_miso    (sdcard_miso)
   );

endmodule

`default_nettype wire

// ==== sector_buffers.sv ====
/*
 * read and write sector buffers, host port and card-side port
 */
`default_nettype none

module sector_buffers import sdspi_buf_pkg::*; (
   input  logic                  controller_clk,
   // host side
   input  logic [buf_addr_w-1:0] xfer_addr,
   input  logic [word_w-1:0]     xfer_in,
   input  logic                  xfer_write,
   output logic [word_w-1:0]     xfer_out,
   // sequencer side
   input  logic [buf_addr_w-1:0] wbuf_index,
   output buf_word_u             wbuf_word,
   input  logic [buf_addr_w-1:0] rbuf_index,
   input  buf_word_u             rbuf_word,
   input  logic                  rbuf_we
);

   buf_word_u wmem [buf_depth];  // host -> card
   buf_word_u rmem [buf_depth];  // card -> host

   // write buffer, filled by the host
   always_ff @(posedge controller_clk) begin
      if (xfer_write)
         wmem[xfer_addr].word <= xfer_in;
      wbuf_word <= wmem[wbuf_index];  // sequencer fetch
   end

   // read buffer, filled by the sequencer
   always_ff @(posedge controller_clk) begin
      if (rbuf_we)
         rmem[rbuf_index] <= rbuf_word;
      xfer_out <= rmem[xfer_addr].word;
   end

endmodule

`default_nettype wire

// ==== spi_byte_engine.sv ====
/*
 * card clock divider and 8-bit full-duplex SPI shifter, mode 0
 */
`default_nettype none

module spi_byte_engine import sdspi_buf_pkg::*; (
   input  logic       controller_clk,
   input  logic       reset,
   input  logic       fast,
   input  logic       byte_req,
   input  logic [7:0] tx_byte,
   output logic       byte_ack,
   output logic [7:0] rx_byte,
   output logic       sdcard_sclk,
   output logic       sdcard_mosi,
   input  logic       sdcard_miso
);

   logic       busy;
   logic       fast_q;    // speed held for the whole byte
   logic [5:0] div_cnt;
   logic [5:0] half_lim;  // controller clocks per sclk half period, minus one
   logic [2:0] bit_cnt;
   logic [7:0] tx_sr;

   assign half_lim = 6'((fast_q ? fast_div : slow_div) / 2 - 1);

   always_ff @(posedge controller_clk) begin
      if (reset) begin
         busy        <= 1'b0;
         fast_q      <= 1'b0;
         byte_ack    <= 1'b0;
         div_cnt     <= '0;
         bit_cnt     <= '0;
         sdcard_sclk <= 1'b0;
         sdcard_mosi <= 1'b1;
      end else if (!busy) begin
         if (byte_req && !byte_ack) begin
            busy        <= 1'b1;
            fast_q      <= fast;
            div_cnt     <= '0;
            bit_cnt     <= '0;
            sdcard_mosi <= tx_byte[7];  // MSB set up before first rising edge
            tx_sr       <= {tx_byte[6:0], 1'b1};
         end else if (!byte_req) begin
            byte_ack <= 1'b0;
         end
      end else if (div_cnt != half_lim) begin
         div_cnt <= div_cnt + 1'b1;
      end else begin
         div_cnt     <= '0;
         sdcard_sclk <= !sdcard_sclk;
         if (!sdcard_sclk) begin
            rx_byte <= {rx_byte[6:0], sdcard_miso};  // rising edge, sample
         end else begin
            // falling edge, next bit out or byte finished
            bit_cnt <= bit_cnt + 1'b1;
            if (bit_cnt == 3'd7) begin
               busy        <= 1'b0;
               byte_ack    <= 1'b1;
               sdcard_mosi <= 1'b1;
            end else begin
               sdcard_mosi <= tx_sr[7];
               tx_sr       <= {tx_sr[6:0], 1'b1};
            end
         end
      end
   end

endmodule

`default_nettype wire

// ==== src.f ====
sd_proto_pkg.sv
sdspi_buf_pkg.sv
sector_buffers.sv
card_sequencer.sv
spi_byte_engine.sv
sdspi_top.sv
sd_card_model.sv
sdspi_chk.sv
tb_sdspi.sv

// ==== tb_sdspi.sv ====
/*
 * testbench for the SD SPI controller: start-up, sector reads and
 * writes, four-phase handshake order, address error
 */
`default_nettype none

module tb_sdspi import sdspi_buf_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int cycle_limit = 400000;  // start-up ~40k plus eight operations ~11k each

   logic                     controller_clk;
   logic                     reset;
   logic [sector_addr_w-1:0] sdcard_addr;
   logic                     read_start, read_ack, write_start, write_ack;
   logic                     idle, read_done, write_done, error;
   logic [buf_addr_w-1:0]    xfer_addr;
   logic [word_w-1:0]        xfer_in;
   logic                     xfer_write;
   logic [word_w-1:0]        xfer_out;
   logic                     sdcard_cs, sdcard_sclk, sdcard_mosi, sdcard_miso;

   int                       seed    = 32'h2d4d6bf8;
   int                       cycles  = 0;
   logic [15:0]              written [int];  // sector * 256 + word
   logic                     rd_active = 1'b0;
   int                       rd_sector = 0;
   logic                     rd_valid_q = 1'b0;
   int                       rd_sector_q;
   logic [buf_addr_w-1:0]    rd_index_q;

   sdspi_top i_sdspi_top (
      .controller_clk (controller_clk),
      .reset          (reset),
      .sdcard_addr    (sdcard_addr),
      .read_start     (read_start),
      .read_ack       (read_ack),
      .write_start    (write_start),
      .write_ack      (write_ack),
      .idle           (idle),
      .read_done      (read_done),
      .write_done     (write_done),
      .error          (error),
      .xfer_addr      (xfer_addr),
      .xfer_in        (xfer_in),
      .xfer_write     (xfer_write),
      .xfer_out       (xfer_out),
      .sdcard_cs      (sdcard_cs),
      .sdcard_sclk    (sdcard_sclk),
      .sdcard_mosi    (sdcard_mosi),
      .sdcard_miso    (sdcard_miso)
   );

   sd_card_model i_sd_card_model (
      .sdcard_cs   (sdcard_cs),
      .sdcard_sclk (sdcard_sclk),
      .sdcard_mosi (sdcard_mosi),
      .sdcard_miso (sdcard_miso)
   );

   initial begin
      controller_clk = 1'b0;
      forever #50 controller_clk = ~controller_clk;
   end

   always @(posedge controller_clk) begin
      cycles++;
      if (cycles >= cycle_limit) begin
         $display("timeout: test did not finish within %0d cycles", cycle_limit);
         $display("TB FAILED");
         $fatal(1, "timeout");
      end
   end

   // expected word k of sector a, byte 2k+1 high and byte 2k low
   function automatic logic [15:0] ref_word(input int a, input int k);
      logic [7:0] lo;
      logic [7:0] hi;
      if (written.exists(a * buf_depth + k))
         return written[a * buf_depth + k];
      lo = 8'(a * 3 + 2 * k);
      hi = 8'(a * 3 + 2 * k + 1);
      return {hi, lo};
   endfunction

   task automatic check_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
      if (got !== exp) begin
         $display("[ERROR] %0d ns %s got %0h expected %0h", $time, name, got, exp);
         $display("TB FAILED");
         $fatal(1, "value mismatch");
      end
   endtask

   // **************************************************
   // read-buffer compare, one cycle behind the address
   // **************************************************
   always @(posedge controller_clk) begin
      rd_valid_q  <= rd_active;
      rd_index_q  <= xfer_addr;
      rd_sector_q <= rd_sector;
   end

   always @(negedge controller_clk) begin
      if (rd_valid_q)
         check_value("xfer_out", xfer_out, ref_word(rd_sector_q, rd_index_q));
   end

   task automatic read_buffer(input int sector);
      rd_sector = sector;
      rd_active = 1'b1;
      for (int k = 0; k < buf_depth; k++) begin
         xfer_addr = buf_addr_w'(k);
         @(negedge controller_clk);
      end
      rd_active = 1'b0;
      @(negedge controller_clk);
   endtask

   task automatic fill_write_buffer(input int sector);
      logic [15:0] w;
      for (int k = 0; k < buf_depth; k++) begin
         w = 16'($random(seed));
         written[sector * buf_depth + k] = w;
         xfer_addr  = buf_addr_w'(k);
         xfer_in    = w;
         xfer_write = 1'b1;
         @(negedge controller_clk);
      end
      xfer_write = 1'b0;
   endtask

   task automatic start_op(input logic is_write, input int sector);
      while (!idle)
         @(negedge controller_clk);
      sdcard_addr = sector_addr_w'(sector);
      if (is_write)
         write_start = 1'b1;
      else
         read_start = 1'b1;
   endtask

   task automatic wait_for_done(input logic is_write);
      while (!(is_write ? write_done : read_done))
         @(negedge controller_clk);
   endtask

   // done must hold until ack, then fall, then idle
   task automatic finish_op(input logic is_write, input logic exp_err);
      string done_name;
      if (is_write)
         done_name = "write_done";
      else
         done_name = "read_done";
      wait_for_done(is_write);
      check_value("error", error, exp_err);
      repeat (4) begin
         @(negedge controller_clk);
         check_value(done_name, is_write ? write_done : read_done, 1'b1);
      end
      if (is_write) begin
         write_start = 1'b0;
         write_ack   = 1'b1;
      end else begin
         read_start = 1'b0;
         read_ack   = 1'b1;
      end
      while (is_write ? write_done : read_done)
         @(negedge controller_clk);
      check_value("idle", idle, 1'b1);
      write_ack = 1'b0;
      read_ack  = 1'b0;
      @(negedge controller_clk);
   endtask

   initial begin
      reset       = 1'b1;
      sdcard_addr = '0;
      read_start  = 1'b0;
      read_ack    = 1'b0;
      write_start = 1'b0;
      write_ack   = 1'b0;
      xfer_addr   = '0;
      xfer_in     = '0;
      xfer_write  = 1'b0;
      repeat (16) @(negedge controller_clk);
      reset = 1'b0;
      check_value("idle", idle, 1'b0);
      check_value("read_done", read_done, 1'b0);
      check_value("write_done", write_done, 1'b0);
      check_value("error", error, 1'b0);
      check_value("sdcard_cs", sdcard_cs, 1'b1);    // card deselected
      check_value("sdcard_mosi", sdcard_mosi, 1'b1);
      check_value("sdcard_sclk", sdcard_sclk, 1'b0);

      while (!idle)  // start-up at slow clock
         @(negedge controller_clk);
      check_value("error", error, 1'b0);

      start_op(1'b0, 5);
      finish_op(1'b0, 1'b0);
      read_buffer(5);

      fill_write_buffer(9);
      start_op(1'b1, 9);
      finish_op(1'b1, 1'b0);
      start_op(1'b0, 9);
      finish_op(1'b0, 1'b0);
      read_buffer(9);

      // write request held behind the read ack
      fill_write_buffer(12);
      start_op(1'b0, 5);
      wait_for_done(1'b0);
      read_start  = 1'b0;
      read_ack    = 1'b1;
      sdcard_addr = sector_addr_w'(12);
      write_start = 1'b1;
      while (read_done)
         @(negedge controller_clk);
      repeat (20) begin
         @(negedge controller_clk);
         check_value("idle", idle, 1'b1);
         check_value("write_done", write_done, 1'b0);
      end
      read_ack = 1'b0;
      finish_op(1'b1, 1'b0);
      read_buffer(5);
      start_op(1'b0, 12);
      finish_op(1'b0, 1'b0);
      read_buffer(12);

      // sector beyond the card, then a good read clears error
      start_op(1'b0, 100);
      finish_op(1'b0, 1'b1);
      start_op(1'b0, 5);
      finish_op(1'b0, 1'b0);
      read_buffer(5);

      check_value("assertion failures", i_sdspi_top.i_sdspi_chk.fail_cnt, 0);
      $display("TB PASSED");
      $finish;
   end

endmodule

`default_nettype wire
